// File: filelist.f
rtl/vrf_cfg_pkg.sv
rtl/vrf_msg_pkg.sv
rtl/vrf_dispatch.sv
rtl/vrf_port_seq.sv
rtl/vrf_storage.sv
rtl/vrf_collect.sv
rtl/vrf_top.sv
tests/vrf_tb.sv

// File: rtl/vrf_cfg_pkg.sv
package vrf_cfg_pkg;

  // default geometry, the top level hands these down as module parameters
  parameter int VLEN_DEF       = 128;  // bits per vector register
  parameter int DATA_WIDTH_DEF = 32;   // bits per storage beat
  parameter int ADDR_WIDTH_DEF = 5;    // 32 vector registers
  parameter int PORTS_DEF      = 3;    // sequencers and storage ports

  // request tag, echoed back on the response
  parameter int TAG_WIDTH = 4;

  // field widths of the message structs
  // these follow the defaults, not the per-instance parameters
  parameter int MASK_WIDTH = VLEN_DEF / 8;  // one enable per byte of a vector
  parameter int BEATS_DEF  = VLEN_DEF / DATA_WIDTH_DEF;
  parameter int BIDX_WIDTH = (BEATS_DEF > 1) ? $clog2(BEATS_DEF) : 1;
  parameter int STRB_WIDTH = DATA_WIDTH_DEF / 8;  // one enable per byte of a beat

endpackage

// File: rtl/vrf_collect.sv
`timescale 1ns/10ps

module vrf_collect #(
  parameter int PORTS = vrf_cfg_pkg::PORTS_DEF
) (
  input  logic                   clk,
  input  logic                   rst,
  input  vrf_msg_pkg::vrf_rsp_t  done_rsp [PORTS],
  input  logic [PORTS-1:0]       done_valid,
  output logic [PORTS-1:0]       done_ready,
  output vrf_msg_pkg::vrf_rsp_t  rsp,
  output logic                   rsp_valid,
  input  logic                   rsp_ready
);

  localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

  logic [PTR_W-1:0] last_pick;
  logic [PTR_W-1:0] pick;
  logic             any_done;
  logic             take;

  // round-robin over finished lanes
  always_comb begin
    int cand;
    pick     = last_pick;
    any_done = 1'b0;
    for (int k = 1; k <= PORTS; k++) begin
      cand = (int'(last_pick) + k) % PORTS;
      if (!any_done && done_valid[cand]) begin
        any_done = 1'b1;
        pick     = PTR_W'(cand);
      end
    end
  end

  // output register is empty or drains this cycle
  assign take = any_done && (!rsp_valid || rsp_ready);

  genvar i;
  generate
    for (i = 0; i < PORTS; i++) begin : g_ready
      assign done_ready[i] = take && (pick == PTR_W'(i));
    end
  endgenerate

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rsp_valid <= 1'b0;
      last_pick <= PTR_W'(PORTS - 1);
    end else begin
      if (take) begin
        rsp_valid <= 1'b1;
        last_pick <= pick;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp <= done_rsp[pick];
    end
  end

endmodule

// File: rtl/vrf_dispatch.sv
`timescale 1ns/10ps

module vrf_dispatch #(
  parameter int ADDR_WIDTH = vrf_cfg_pkg::ADDR_WIDTH_DEF,
  parameter int PORTS      = vrf_cfg_pkg::PORTS_DEF
) (
  input  logic                   clk,
  input  logic                   rst,
  input  vrf_msg_pkg::vrf_req_t  req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output vrf_msg_pkg::vrf_req_t  slot_req [PORTS],
  output logic [PORTS-1:0]       slot_valid,
  input  logic [PORTS-1:0]       slot_ready,
  input  logic [PORTS-1:0]       busy,
  input  logic [ADDR_WIDTH-1:0]  busy_vreg [PORTS]
);

  localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

  logic             armed;       // holds req_ready low for the first cycle out of reset
  logic [PTR_W-1:0] last_grant;
  logic [PTR_W-1:0] grant;
  logic             any_idle;
  logic             hit;         // some busy lane owns the requested register

  // first idle lane after the last one granted
  always_comb begin
    int cand;
    grant    = last_grant;
    any_idle = 1'b0;
    for (int k = 1; k <= PORTS; k++) begin
      cand = (int'(last_grant) + k) % PORTS;
      if (!any_idle && slot_ready[cand]) begin
        any_idle = 1'b1;
        grant    = PTR_W'(cand);
      end
    end
  end

  // scoreboard: one operation per register at a time
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < PORTS; i++) begin
      if (busy[i] && (busy_vreg[i] == req.vreg[ADDR_WIDTH-1:0])) begin
        hit = 1'b1;
      end
    end
  end

  assign req_ready = armed && any_idle && !hit;

  genvar i;
  generate
    for (i = 0; i < PORTS; i++) begin : g_slot
      assign slot_req[i]   = req;  // payload fans out, valid picks the lane
      assign slot_valid[i] = req_valid && req_ready && (grant == PTR_W'(i));
    end
  endgenerate

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      armed      <= 1'b0;
      last_grant <= PTR_W'(PORTS - 1);  // so lane 0 goes first
    end else begin
      armed <= 1'b1;
      if (req_valid && req_ready) begin
        last_grant <= grant;
      end
    end
  end

endmodule

// File: rtl/vrf_msg_pkg.sv
package vrf_msg_pkg;

  typedef enum logic {
    VRF_RD = 1'b0,
    VRF_WR = 1'b1
  } vrf_op_e;

  // whole-vector request from the requester
  typedef struct packed {
    vrf_op_e                                 op;
    logic [vrf_cfg_pkg::TAG_WIDTH-1:0]       tag;
    logic [vrf_cfg_pkg::ADDR_WIDTH_DEF-1:0]  vreg;
    logic [vrf_cfg_pkg::MASK_WIDTH-1:0]      mask;   // byte enables, writes only
    logic [vrf_cfg_pkg::VLEN_DEF-1:0]        wdata;
  } vrf_req_t;

  // one response per request
  typedef struct packed {
    vrf_op_e                            op;
    logic [vrf_cfg_pkg::TAG_WIDTH-1:0]  tag;
    logic [vrf_cfg_pkg::VLEN_DEF-1:0]   rdata;  // zero for writes
  } vrf_rsp_t;

  // one beat from a sequencer to its storage port
  typedef struct packed {
    logic                                    en;
    logic                                    we;
    logic [vrf_cfg_pkg::ADDR_WIDTH_DEF-1:0]  vreg;
    logic [vrf_cfg_pkg::BIDX_WIDTH-1:0]      idx;   // which word of the vector
    logic [vrf_cfg_pkg::STRB_WIDTH-1:0]      strb;
    logic [vrf_cfg_pkg::DATA_WIDTH_DEF-1:0]  data;
  } vrf_beat_t;

endpackage

// File: rtl/vrf_port_seq.sv
`timescale 1ns/10ps

module vrf_port_seq #(
  parameter int VLEN       = vrf_cfg_pkg::VLEN_DEF,
  parameter int DATA_WIDTH = vrf_cfg_pkg::DATA_WIDTH_DEF,
  parameter int ADDR_WIDTH = vrf_cfg_pkg::ADDR_WIDTH_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  vrf_msg_pkg::vrf_req_t    slot_req,
  input  logic                     slot_valid,
  output logic                     slot_ready,
  output logic                     busy,
  output logic [ADDR_WIDTH-1:0]    busy_vreg,
  output vrf_msg_pkg::vrf_beat_t   beat,
  input  logic [DATA_WIDTH-1:0]    rd_data,
  output vrf_msg_pkg::vrf_rsp_t    done_rsp,
  output logic                     done_valid,
  input  logic                     done_ready
);

  import vrf_msg_pkg::*;

  localparam int BEATS      = VLEN / DATA_WIDTH;
  localparam int BEAT_BITS  = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int BEAT_BYTES = DATA_WIDTH / 8;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,    // one beat per cycle
    LAST_RD,  // last read word is on rd_data
    DONE      // waiting for the collector
  } seq_state_e;

  seq_state_e                         state;
  vrf_req_t                           req_q;
  logic [BEAT_BITS-1:0]               idx;
  logic                               last_beat;
  logic                               rd_vld;  // rd_data carries a word for us this cycle
  logic [BEAT_BITS-1:0]               rd_idx;
  logic [BEATS-1:0][DATA_WIDTH-1:0]   gather;
  logic [BEATS-1:0][DATA_WIDTH-1:0]   rd_vec;

  assign last_beat = (idx == BEAT_BITS'(BEATS - 1));

  // current beat, sliced out of the latched request
  always_comb begin
    beat.en   = (state == ISSUE);
    beat.we   = (req_q.op == VRF_WR);
    beat.vreg = req_q.vreg;
    beat.idx  = idx;
    beat.strb = req_q.mask[idx*BEAT_BYTES +: BEAT_BYTES];
    beat.data = req_q.wdata[idx*DATA_WIDTH +: DATA_WIDTH];
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state  <= IDLE;
      idx    <= '0;
      rd_vld <= 1'b0;
      rd_idx <= '0;
    end else begin
      rd_vld <= beat.en && !beat.we;  // storage answers one cycle later
      rd_idx <= idx;
      case (state)
        IDLE: begin
          if (slot_valid) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          idx <= last_beat ? '0 : idx + 1'b1;
          if (last_beat) begin
            state <= (req_q.op == VRF_WR) ? DONE : LAST_RD;
          end
        end
        LAST_RD: state <= done_ready ? IDLE : DONE;
        DONE: begin
          if (done_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && slot_valid) begin
      req_q <= slot_req;
    end
    if (rd_vld) begin
      gather[rd_idx] <= rd_data;
    end
  end

  // last word bypasses the gather register so the response is not a cycle late
  always_comb begin
    rd_vec = gather;
    if (rd_vld) begin
      rd_vec[rd_idx] = rd_data;
    end
  end

  assign done_rsp.op    = req_q.op;
  assign done_rsp.tag   = req_q.tag;
  assign done_rsp.rdata = (req_q.op == VRF_WR) ? '0 : rd_vec;

  assign done_valid = (state == LAST_RD) || (state == DONE);
  assign slot_ready = (state == IDLE);
  assign busy       = (state != IDLE);  // held until the response is taken
  assign busy_vreg  = req_q.vreg[ADDR_WIDTH-1:0];

endmodule

// File: rtl/vrf_storage.sv
`timescale 1ns/10ps

module vrf_storage #(
  parameter int VLEN       = vrf_cfg_pkg::VLEN_DEF,
  parameter int DATA_WIDTH = vrf_cfg_pkg::DATA_WIDTH_DEF,
  parameter int ADDR_WIDTH = vrf_cfg_pkg::ADDR_WIDTH_DEF,
  parameter int PORTS      = vrf_cfg_pkg::PORTS_DEF
) (
  input  logic                    clk,
  input  vrf_msg_pkg::vrf_beat_t  beat [PORTS],
  output logic [DATA_WIDTH-1:0]   rd_data [PORTS]
);

  localparam int BEATS      = VLEN / DATA_WIDTH;
  localparam int BEAT_BITS  = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int BEAT_BYTES = DATA_WIDTH / 8;
  localparam int NUM_VECS   = 1 << ADDR_WIDTH;

  // each vector is BEATS words, addressed by register and word index
  logic [DATA_WIDTH-1:0] mem [NUM_VECS][BEATS];

  logic [ADDR_WIDTH-1:0] vaddr [PORTS];
  logic [BEAT_BITS-1:0]  baddr [PORTS];

  always_comb begin
    for (int p = 0; p < PORTS; p++) begin
      vaddr[p] = beat[p].vreg[ADDR_WIDTH-1:0];
      baddr[p] = beat[p].idx;
    end
  end

  // ports never touch the same register at once, the scoreboard sees to that
  always_ff @(posedge clk) begin
    for (int p = 0; p < PORTS; p++) begin
      if (beat[p].en) begin
        if (beat[p].we) begin
          for (int b = 0; b < BEAT_BYTES; b++) begin
            if (beat[p].strb[b]) begin
              mem[vaddr[p]][baddr[p]][b*8 +: 8] <= beat[p].data[b*8 +: 8];
            end
          end
        end else begin
          rd_data[p] <= mem[vaddr[p]][baddr[p]];  // one cycle read latency
        end
      end
    end
  end

endmodule

// File: rtl/vrf_top.sv
`timescale 1ns/10ps

module vrf_top #(
  parameter int VLEN       = vrf_cfg_pkg::VLEN_DEF,
  parameter int DATA_WIDTH = vrf_cfg_pkg::DATA_WIDTH_DEF,
  parameter int ADDR_WIDTH = vrf_cfg_pkg::ADDR_WIDTH_DEF,
  parameter int PORTS      = vrf_cfg_pkg::PORTS_DEF
) (
  input  logic                   clk,
  input  logic                   rst,
  input  vrf_msg_pkg::vrf_req_t  req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output vrf_msg_pkg::vrf_rsp_t  rsp,
  output logic                   rsp_valid,
  input  logic                   rsp_ready
);

  import vrf_msg_pkg::*;

  // dispatcher <-> lanes
  vrf_req_t              slot_req   [PORTS];
  logic [PORTS-1:0]      slot_valid;
  logic [PORTS-1:0]      slot_ready;
  logic [PORTS-1:0]      busy;
  logic [ADDR_WIDTH-1:0] busy_vreg  [PORTS];

  // lanes <-> storage
  vrf_beat_t             beat       [PORTS];
  logic [DATA_WIDTH-1:0] rd_data    [PORTS];

  // lanes <-> collector
  vrf_rsp_t              done_rsp   [PORTS];
  logic [PORTS-1:0]      done_valid;
  logic [PORTS-1:0]      done_ready;

  vrf_dispatch #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .PORTS      (PORTS)
  ) u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .slot_req   (slot_req),
    .slot_valid (slot_valid),
    .slot_ready (slot_ready),
    .busy       (busy),
    .busy_vreg  (busy_vreg)
  );

  genvar i;
  generate
    for (i = 0; i < PORTS; i++) begin : g_seq
      vrf_port_seq #(
        .VLEN       (VLEN),
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
      ) u_seq (
        .clk        (clk),
        .rst        (rst),
        .slot_req   (slot_req[i]),
        .slot_valid (slot_valid[i]),
        .slot_ready (slot_ready[i]),
        .busy       (busy[i]),
        .busy_vreg  (busy_vreg[i]),
        .beat       (beat[i]),
        .rd_data    (rd_data[i]),
        .done_rsp   (done_rsp[i]),
        .done_valid (done_valid[i]),
        .done_ready (done_ready[i])
      );
    end
  endgenerate

  vrf_storage #(
    .VLEN       (VLEN),
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .PORTS      (PORTS)
  ) u_storage (
    .clk     (clk),
    .beat    (beat),
    .rd_data (rd_data)
  );

  vrf_collect #(
    .PORTS (PORTS)
  ) u_collect (
    .clk        (clk),
    .rst        (rst),
    .done_rsp   (done_rsp),
    .done_valid (done_valid),
    .done_ready (done_ready),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready)
  );

endmodule

// File: tests/vrf_stimulus.txt
# R op tag vreg mask wdata : request, op 0 read and 1 write, every field hex
# E tag op rdata : expected response; S waits for all responses; B 1 or 0 sets back-pressure
R 1 0 03 ffff 00112233445566778899aabbccddeeff
E 0 1 0
R 0 1 03 0000 0
E 1 0 00112233445566778899aabbccddeeff
S
# partial write replaces bytes 0, 5, 10 and 15
R 1 2 03 8421 f0e0d0c0b0a090807060504030201000
E 2 1 0
R 0 3 03 0000 0
E 3 0 f011223344a06677889950bbccddee00
S
# back-to-back requests spread over every lane
R 1 4 05 ffff 0123456789abcdef0123456789abcdef
E 4 1 0
R 1 5 06 ffff deadbeef00000001deadbeef00000002
E 5 1 0
R 1 6 07 ffff 5a5a5a5aa5a5a5a5ffff000012345678
E 6 1 0
S
R 0 7 05 0000 0
E 7 0 0123456789abcdef0123456789abcdef
R 0 8 06 0000 0
E 8 0 deadbeef00000001deadbeef00000002
R 0 9 07 0000 0
E 9 0 5a5a5a5aa5a5a5a5ffff000012345678
S
# read right behind a write to the same register
R 1 a 08 ffff 11112222333344445555666677778888
E a 1 0
R 0 b 08 0000 0
E b 0 11112222333344445555666677778888
S
B 1
R 0 c 03 0000 0
E c 0 f011223344a06677889950bbccddee00
R 0 d 06 0000 0
E d 0 deadbeef00000001deadbeef00000002
R 1 e 07 000f abcdef01
E e 1 0
R 0 f 07 0000 0
E f 0 5a5a5a5aa5a5a5a5ffff0000abcdef01
R 0 0 05 0000 0
E 0 0 0123456789abcdef0123456789abcdef
R 0 1 08 0000 0
E 1 0 11112222333344445555666677778888
R 1 2 06 f000 aabbccdd000000000000000000000000
E 2 1 0
R 0 3 06 0000 0
E 3 0 aabbccdd00000001deadbeef00000002
S
B 0

// File: tests/vrf_tb.sv
`timescale 1ns/10ps

module vrf_tb;

  import vrf_cfg_pkg::*;
  import vrf_msg_pkg::*;

  localparam int REQ_LIMIT   = 400;   // cycles a request may wait for req_ready
  localparam int DRAIN_LIMIT = 1000;  // cycles for all open responses to arrive

  logic     clk;
  logic     rst;
  vrf_req_t req;
  logic     req_valid;
  logic     req_ready;
  vrf_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;

  vrf_rsp_t                  exp_rsp [1 << TAG_WIDTH];   // expected response per tag
  logic [ADDR_WIDTH_DEF-1:0] exp_vreg [1 << TAG_WIDTH];  // register each tag works on
  logic [TAG_WIDTH-1:0]      open_tags [$];              // open tags in request order
  logic [(1<<TAG_WIDTH)-1:0] pending = '0;
  int                        outstanding = 0;
  int                        mismatches = 0;
  int                        other_errors = 0;
  int                        checked = 0;
  logic                      bp_on = 1'b0;
  logic                      aborted = 1'b0;

  vrf_top #(
    .VLEN       (VLEN_DEF),
    .DATA_WIDTH (DATA_WIDTH_DEF),
    .ADDR_WIDTH (ADDR_WIDTH_DEF),
    .PORTS      (PORTS_DEF)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_tag(input logic [TAG_WIDTH-1:0] got, input logic [TAG_WIDTH-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH rsp.tag got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_op(input vrf_op_e got, input vrf_op_e exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH rsp.op got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_rsp_data(input logic [VLEN_DEF-1:0] got, input logic [VLEN_DEF-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH rsp.rdata got 0x%h expected 0x%h", got, exp);
    end
  endtask

  // each response is matched by tag and must be the oldest open one on its register
  always @(posedge clk) begin
    logic [TAG_WIDTH-1:0] oldest;
    int                   pos;
    if (rst && rsp_valid && rsp_ready) begin
      if (!pending[rsp.tag]) begin
        other_errors++;
        $display("error: response for tag 0x%h arrived with no request open", rsp.tag);
      end else begin
        oldest = rsp.tag;
        pos    = -1;
        for (int k = open_tags.size() - 1; k >= 0; k--) begin
          if (exp_vreg[open_tags[k]] == exp_vreg[rsp.tag]) begin
            oldest = open_tags[k];
          end
          if (open_tags[k] == rsp.tag) begin
            pos = k;
          end
        end
        check_tag(rsp.tag, oldest);
        check_op(rsp.op, exp_rsp[rsp.tag].op);
        check_rsp_data(rsp.rdata, exp_rsp[rsp.tag].rdata);
        if (pos >= 0) begin
          open_tags.delete(pos);
        end
        pending[rsp.tag] = 1'b0;
        outstanding--;
        checked++;
      end
    end
  end

  // rsp_ready goes low in random stretches while back-pressure is on
  initial begin
    int low_left;
    void'($urandom(32'ha62aca25));
    low_left  = 0;
    rsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (!bp_on) begin
        rsp_ready = 1'b1;
      end else if (low_left > 0) begin
        rsp_ready = 1'b0;
        low_left--;
      end else if (($urandom % 3) == 0) begin
        rsp_ready = 1'b0;
        low_left  = $urandom % 6;
      end else begin
        rsp_ready = 1'b1;
      end
    end
  end

  task automatic send_req(input vrf_op_e op, input logic [TAG_WIDTH-1:0] tag,
                          input logic [ADDR_WIDTH_DEF-1:0] vreg,
                          input logic [MASK_WIDTH-1:0] mask, input logic [VLEN_DEF-1:0] data);
    int   cycles;
    logic accepted;
    exp_vreg[tag] = vreg;
    req.op    = op;
    req.tag   = tag;
    req.vreg  = vreg;
    req.mask  = mask;
    req.wdata = data;
    req_valid = 1'b1;
    cycles    = 0;
    accepted  = 1'b0;
    while (!accepted && cycles < REQ_LIMIT) begin
      @(posedge clk);
      accepted = req_ready;  // transfer happens on this edge
      cycles++;
    end
    #2;
    req_valid = 1'b0;
    if (!accepted) begin
      other_errors++;
      $display("error: request with tag 0x%h was not accepted in time", tag);
      aborted = 1'b1;
    end
  endtask

  task automatic expect_rsp(input logic [TAG_WIDTH-1:0] tag, input vrf_op_e op,
                            input logic [VLEN_DEF-1:0] data);
    if (pending[tag]) begin
      other_errors++;
      $display("error: tag 0x%h reused while its response is still open", tag);
    end
    exp_rsp[tag].op    = op;
    exp_rsp[tag].rdata = data;
    pending[tag]       = 1'b1;
    open_tags.push_back(tag);
    outstanding++;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (outstanding > 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (outstanding > 0) begin
      other_errors++;
      $display("error: timed out with %0d responses still missing", outstanding);
      aborted = 1'b1;
    end
  endtask

  initial begin
    integer                fd;
    byte                   kind;
    int                    n;
    logic [8*160-1:0]      line_buf;
    logic [31:0]           f_op;
    logic [31:0]           f_tag;
    logic [31:0]           f_vreg;
    logic [31:0]           f_mask;
    logic [VLEN_DEF-1:0]   f_data;
    rst       = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b1;
    fd  = $fopen("tests/vrf_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("error: could not open tests/vrf_stimulus.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      n = $fscanf(fd, " %c", kind);
      if (n == 1) begin
        case (kind)
          "#": n = $fgets(line_buf, fd);
          "R": begin
            n = $fscanf(fd, "%h %h %h %h %h", f_op, f_tag, f_vreg, f_mask, f_data);
            send_req(vrf_op_e'(f_op[0]), f_tag[TAG_WIDTH-1:0], f_vreg[ADDR_WIDTH_DEF-1:0],
                     f_mask[MASK_WIDTH-1:0], f_data);
          end
          "E": begin
            n = $fscanf(fd, "%h %h %h", f_tag, f_op, f_data);
            expect_rsp(f_tag[TAG_WIDTH-1:0], vrf_op_e'(f_op[0]), f_data);
          end
          "S": wait_drain();
          "B": begin
            n     = $fscanf(fd, "%h", f_op);
            bp_on = f_op[0];
          end
          default: begin
            other_errors++;
            $display("error: unknown line kind in the stimulus file");
            aborted = 1'b1;
          end
        endcase
      end
    end
    if (!aborted) begin
      wait_drain();
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("summary: %0d mismatches, %0d other errors, %0d responses checked",
             mismatches, other_errors, checked);
    if (mismatches == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
